/* Bender.yml */
package:
  name: rob

sources:
  # packages first, then interfaces and design
  - hw/rv_isa_pkg.sv
  - hw/rob_pkg.sv
  - hw/rob_retire_if.sv
  - hw/rob_head_if.sv
  - hw/rob_alloc.sv
  - hw/rob_entry_store.sv
  - hw/rob_commit.sv
  - hw/rob_top.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/rob_tb.sv

/* compile.f */
+incdir+verification
hw/rv_isa_pkg.sv
hw/rob_pkg.sv
hw/rob_retire_if.sv
hw/rob_head_if.sv
hw/rob_alloc.sv
hw/rob_entry_store.sv
hw/rob_commit.sv
hw/rob_top.sv
verification/rob_tb.sv

/* hw/rob_alloc.sv */
`timescale 1ns/10ps

module rob_alloc (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rdy,
    input  logic                           iss_en,
    input  logic [rv_isa_pkg::regnm_w-1:0] iss_regnm,
    output logic                           full,
    output logic                           tag_en,
    output rob_pkg::tag_t                  tag,
    output logic [rv_isa_pkg::regnm_w-1:0] tag_regnm,
    rob_retire_if.alloc                    ret
);

    rob_pkg::tag_t wr_ptr;
    rob_pkg::tag_t wr_ptr_nxt;
    // live entries, up to 31
    logic [rob_pkg::tag_w-1:0] count;

    assign full = (count == rob_pkg::tag_last);

    // grant in the same cycle as the issue request
    assign tag_en    = rdy && iss_en && !full && !ret.flush;
    assign tag       = wr_ptr;
    assign tag_regnm = iss_regnm;

    // skip tag 0 on wrap
    assign wr_ptr_nxt = (wr_ptr == rob_pkg::tag_last) ? rob_pkg::tag_first : wr_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= rob_pkg::tag_first;
            count  <= '0;
        end else if (rdy) begin
            if (ret.flush) begin
                wr_ptr <= rob_pkg::tag_first;
                count  <= '0;
            end else begin
                if (tag_en) begin
                    wr_ptr <= wr_ptr_nxt;
                end
                // grant and retire in one cycle cancel out
                case ({tag_en, ret.retire})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    // every retire releases a slot that the count still holds
    a_retire_not_empty: assert property (
        @(posedge clk) disable iff (rst)
        (rdy && ret.retire) |-> (count != '0)
    );

endmodule

/* hw/rob_commit.sv */
`timescale 1ns/10ps

module rob_commit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rdy,
    rob_head_if.commit                     head,
    rob_retire_if.commit                   ret,
    output logic                           rf_en,
    output logic [rv_isa_pkg::regnm_w-1:0] rf_regnm,
    output logic [rv_isa_pkg::data_w-1:0]  rf_data,
    output rob_pkg::tag_t                  rf_tag,
    output logic                           store_commit_en,
    output rob_pkg::tag_t                  store_commit_tag,
    output logic                           flush,
    output logic [rv_isa_pkg::addr_w-1:0]  redirect_pc
);

    rob_pkg::commit_kind_e kind;
    rob_pkg::tag_t         head_tag;
    rob_pkg::tag_t         head_tag_nxt;
    logic                  flush_q;

    // held through a stall and seen only while rdy is high
    assign flush = flush_q && rdy;

    // classify the head entry
    always_comb begin
        kind = rob_pkg::commit_idle;
        if (rdy && !flush && head.valid) begin
            if (head.is_store) begin
                if (!head.sent) begin
                    kind = rob_pkg::commit_store_req;
                end else if (head.done) begin
                    kind = rob_pkg::commit_store_retire;
                end
            end else if (head.done) begin
                if (head.mispredict) begin
                    kind = rob_pkg::commit_mispredict;
                end else begin
                    kind = rob_pkg::commit_reg;
                end
            end
        end
    end

    // a mispredicted branch still writes its link value
    assign rf_en    = (kind == rob_pkg::commit_reg) || (kind == rob_pkg::commit_mispredict);
    assign rf_regnm = head.regnm;
    assign rf_data  = head.data;
    assign rf_tag   = head_tag;

    assign store_commit_en  = (kind == rob_pkg::commit_store_req);
    assign store_commit_tag = head_tag;

    assign ret.head_tag   = head_tag;
    assign ret.retire     = rf_en || (kind == rob_pkg::commit_store_retire);
    assign ret.store_sent = store_commit_en;
    assign ret.flush      = flush;

    assign head_tag_nxt = (head_tag == rob_pkg::tag_last) ? rob_pkg::tag_first
                                                          : head_tag + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_tag <= rob_pkg::tag_first;
            flush_q  <= 1'b0;
        end else if (rdy) begin
            flush_q <= (kind == rob_pkg::commit_mispredict);
            if (flush) begin
                head_tag <= rob_pkg::tag_first;
            end else if (ret.retire) begin
                head_tag <= head_tag_nxt;
            end
        end
    end

    // redirect target travels with the flush
    always_ff @(posedge clk) begin
        if (kind == rob_pkg::commit_mispredict) begin
            redirect_pc <= head.jump_pc;
        end
    end

    // a store request goes out once per store
    a_store_req_once: assert property (
        @(posedge clk) disable iff (rst)
        store_commit_en |=> !store_commit_en
    );

    // nothing is left at the head after a flush
    a_flush_empties_head: assert property (
        @(posedge clk) disable iff (rst)
        flush |=> !head.valid
    );

endmodule

/* hw/rob_entry_store.sv */
`timescale 1ns/10ps

module rob_entry_store (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rdy,
    input  logic                           dp_en,
    input  rob_pkg::tag_t                  dp_tag,
    input  rv_isa_pkg::op_e                dp_op,
    input  logic                           dp_pred,
    input  logic [rv_isa_pkg::regnm_w-1:0] dp_regnm,
    input  logic                           ex_en,
    input  rob_pkg::tag_t                  ex_tag,
    input  logic [rv_isa_pkg::data_w-1:0]  ex_data,
    input  logic                           ex_actual,
    input  logic [rv_isa_pkg::addr_w-1:0]  ex_jump_pc,
    input  logic                           slb_en,
    input  rob_pkg::tag_t                  slb_tag,
    input  logic [rv_isa_pkg::data_w-1:0]  slb_data,
    rob_retire_if.store                    ret,
    rob_head_if.store                      head
);

    // control flags, one bit per slot
    logic [rob_pkg::rob_depth-1:0] valid;
    logic [rob_pkg::rob_depth-1:0] done;
    logic [rob_pkg::rob_depth-1:0] sent;

    // per-slot payload
    logic                           is_store  [rob_pkg::rob_depth];
    logic                           predicted [rob_pkg::rob_depth];
    logic                           actual    [rob_pkg::rob_depth];
    logic [rv_isa_pkg::data_w-1:0]  data      [rob_pkg::rob_depth];
    logic [rv_isa_pkg::regnm_w-1:0] regnm     [rob_pkg::rob_depth];
    logic [rv_isa_pkg::addr_w-1:0]  jump_pc   [rob_pkg::rob_depth];

    logic dp_is_store;

    assign dp_is_store = dp_op inside {rv_isa_pkg::op_sb, rv_isa_pkg::op_sh, rv_isa_pkg::op_sw};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            done  <= '0;
            sent  <= '0;
        end else if (rdy) begin
            if (ret.flush) begin
                valid <= '0;
                done  <= '0;
                sent  <= '0;
            end else begin
                if (ret.retire) begin
                    valid[ret.head_tag] <= 1'b0;
                    done[ret.head_tag]  <= 1'b0;
                    sent[ret.head_tag]  <= 1'b0;
                end
                // a store counts as done only once the store buffer
                // answers its request, so drop any earlier done here
                if (ret.store_sent) begin
                    sent[ret.head_tag] <= 1'b1;
                    done[ret.head_tag] <= 1'b0;
                end
                if (dp_en) begin
                    valid[dp_tag] <= 1'b1;
                    done[dp_tag]  <= 1'b0;
                    sent[dp_tag]  <= 1'b0;
                end
                // completions last, they win over the clear above
                if (ex_en) begin
                    done[ex_tag] <= 1'b1;
                end
                if (slb_en) begin
                    done[slb_tag] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (dp_en) begin
                is_store[dp_tag]  <= dp_is_store;
                predicted[dp_tag] <= dp_pred;
                // no mispredict until execute says otherwise
                actual[dp_tag]    <= dp_pred;
                regnm[dp_tag]     <= dp_regnm;
            end
            if (ex_en) begin
                data[ex_tag]    <= ex_data;
                actual[ex_tag]  <= ex_actual;
                jump_pc[ex_tag] <= ex_jump_pc;
            end
            if (slb_en) begin
                data[slb_tag] <= slb_data;
            end
        end
    end

    // head entry, read straight out of the arrays
    assign head.valid      = valid[ret.head_tag];
    assign head.done       = done[ret.head_tag];
    assign head.is_store   = is_store[ret.head_tag];
    assign head.sent       = sent[ret.head_tag];
    assign head.mispredict = predicted[ret.head_tag] != actual[ret.head_tag];
    assign head.data       = data[ret.head_tag];
    assign head.regnm      = regnm[ret.head_tag];
    assign head.jump_pc    = jump_pc[ret.head_tag];

    // completions name a live entry, possibly one dispatched this cycle
    a_ex_live_tag: assert property (
        @(posedge clk) disable iff (rst)
        (rdy && ex_en) |-> (ex_tag != rob_pkg::tag_none &&
                            (valid[ex_tag] || (dp_en && dp_tag == ex_tag)))
    );

    a_slb_live_tag: assert property (
        @(posedge clk) disable iff (rst)
        (rdy && slb_en) |-> (slb_tag != rob_pkg::tag_none &&
                             (valid[slb_tag] || (dp_en && dp_tag == slb_tag)))
    );

endmodule

/* hw/rob_head_if.sv */
`timescale 1ns/10ps

interface rob_head_if;

    // flags of the entry at the head pointer
    logic valid;
    logic done;
    logic is_store;
    logic sent;
    logic mispredict;

    // payload of the entry at the head pointer
    logic [rv_isa_pkg::data_w-1:0]  data;
    logic [rv_isa_pkg::regnm_w-1:0] regnm;
    logic [rv_isa_pkg::addr_w-1:0]  jump_pc;

    modport store (
        output valid,
        output done,
        output is_store,
        output sent,
        output mispredict,
        output data,
        output regnm,
        output jump_pc
    );

    modport commit (
        input valid,
        input done,
        input is_store,
        input sent,
        input mispredict,
        input data,
        input regnm,
        input jump_pc
    );

endinterface

/* hw/rob_pkg.sv */
package rob_pkg;

    // tags double as slot indices, so the depth follows the tag width
    localparam int tag_w     = 5;
    localparam int rob_depth = 32;

    // tag 0 means no tag; live tags run 1..31 and wrap
    localparam logic [tag_w-1:0] tag_none  = 5'd0;
    localparam logic [tag_w-1:0] tag_last  = 5'd31;
    localparam logic [tag_w-1:0] tag_first = 5'd1;

    typedef logic [tag_w-1:0] tag_t;

    // what the head of the buffer does this cycle
    typedef enum logic [2:0] {
        commit_idle         = 3'd0,
        commit_reg          = 3'd1,
        commit_store_req    = 3'd2,
        commit_store_retire = 3'd3,
        commit_mispredict   = 3'd4
    } commit_kind_e;

endpackage

/* hw/rob_retire_if.sv */
`timescale 1ns/10ps

interface rob_retire_if;

    // head pointer owned by the commit block
    rob_pkg::tag_t head_tag;

    // head entry leaves at the next edge
    logic retire;

    // store request of the head entry has gone out
    logic store_sent;

    // one cycle, empties the whole buffer
    logic flush;

    modport commit (
        output head_tag,
        output retire,
        output store_sent,
        output flush
    );

    modport alloc (
        input retire,
        input flush
    );

    modport store (
        input head_tag,
        input retire,
        input store_sent,
        input flush
    );

endinterface

/* hw/rob_top.sv */
`timescale 1ns/10ps

module rob_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rdy,
    // issue
    input  logic                           iss_en,
    input  logic [rv_isa_pkg::regnm_w-1:0] iss_regnm,
    output logic                           full,
    output logic                           tag_en,
    output rob_pkg::tag_t                  tag,
    output logic [rv_isa_pkg::regnm_w-1:0] tag_regnm,
    // dispatch
    input  logic                           dp_en,
    input  rob_pkg::tag_t                  dp_tag,
    input  rv_isa_pkg::op_e                dp_op,
    input  logic                           dp_pred,
    input  logic [rv_isa_pkg::regnm_w-1:0] dp_regnm,
    // execute results
    input  logic                           ex_en,
    input  rob_pkg::tag_t                  ex_tag,
    input  logic [rv_isa_pkg::data_w-1:0]  ex_data,
    input  logic                           ex_actual,
    input  logic [rv_isa_pkg::addr_w-1:0]  ex_jump_pc,
    // store/load buffer
    input  logic                           slb_en,
    input  rob_pkg::tag_t                  slb_tag,
    input  logic [rv_isa_pkg::data_w-1:0]  slb_data,
    output logic                           store_commit_en,
    output rob_pkg::tag_t                  store_commit_tag,
    // register file write back
    output logic                           rf_en,
    output logic [rv_isa_pkg::regnm_w-1:0] rf_regnm,
    output logic [rv_isa_pkg::data_w-1:0]  rf_data,
    output rob_pkg::tag_t                  rf_tag,
    // mispredict
    output logic                           flush,
    output logic [rv_isa_pkg::addr_w-1:0]  redirect_pc
);

    rob_retire_if ret_if ();
    rob_head_if   head_if ();

    rob_alloc i_alloc (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .iss_en    (iss_en),
        .iss_regnm (iss_regnm),
        .full      (full),
        .tag_en    (tag_en),
        .tag       (tag),
        .tag_regnm (tag_regnm),
        .ret       (ret_if.alloc)
    );

    rob_entry_store i_entry_store (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .dp_en      (dp_en),
        .dp_tag     (dp_tag),
        .dp_op      (dp_op),
        .dp_pred    (dp_pred),
        .dp_regnm   (dp_regnm),
        .ex_en      (ex_en),
        .ex_tag     (ex_tag),
        .ex_data    (ex_data),
        .ex_actual  (ex_actual),
        .ex_jump_pc (ex_jump_pc),
        .slb_en     (slb_en),
        .slb_tag    (slb_tag),
        .slb_data   (slb_data),
        .ret        (ret_if.store),
        .head       (head_if.store)
    );

    rob_commit i_commit (
        .clk              (clk),
        .rst              (rst),
        .rdy              (rdy),
        .head             (head_if.commit),
        .ret              (ret_if.commit),
        .rf_en            (rf_en),
        .rf_regnm         (rf_regnm),
        .rf_data          (rf_data),
        .rf_tag           (rf_tag),
        .store_commit_en  (store_commit_en),
        .store_commit_tag (store_commit_tag),
        .flush            (flush),
        .redirect_pc      (redirect_pc)
    );

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    // architectural widths of the RV32I base
    localparam int data_w  = 32;
    localparam int addr_w  = 32;
    localparam int regnm_w = 5;

    // opcode classes as seen by the reorder buffer
    // op_sb, op_sh and op_sw mark a store
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_load   = 3'd1,
        op_branch = 3'd2,
        op_jump   = 3'd3,
        op_sb     = 3'd4,
        op_sh     = 3'd5,
        op_sw     = 3'd6
    } op_e;

endpackage

/* verification/rob_golden.txt */
# kind (0 alu, 1 store, 2 branch, 3 end of batch) regnm data pred actual jump_pc commit
# commit is 0 for instructions younger than a mispredicted branch
0 01 00001111 0 0 00000000 1
0 02 deadbeef 0 0 00000000 1
1 00 12345678 0 0 00000000 1
0 03 a5a5a5a5 0 0 00000000 1
0 1f 00000042 0 0 00000000 1
3 00 00000000 0 0 00000000 0
2 01 00000100 1 1 00000200 1
1 00 cafef00d 0 0 00000000 1
0 04 0badc0de 0 0 00000000 1
3 00 00000000 0 0 00000000 0
0 05 00000005 0 0 00000000 1
2 06 00001004 0 1 00002000 1
0 07 77777777 0 0 00000000 0
1 00 88888888 0 0 00000000 0
0 08 99999999 0 0 00000000 0
3 00 00000000 0 0 00000000 0
0 09 00000009 0 0 00000000 1
1 00 5555aaaa 0 0 00000000 1
0 0a 0000000a 0 0 00000000 1
3 00 00000000 0 0 00000000 0

/* verification/rob_tb_checks.svh */
`ifndef ROB_TB_CHECKS_SVH
`define ROB_TB_CHECKS_SVH

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
endfunction

task automatic check_tag(input string name, input rob_pkg::tag_t got,
                         input rob_pkg::tag_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_reg(input string name, input logic [rv_isa_pkg::regnm_w-1:0] got,
                         input logic [rv_isa_pkg::regnm_w-1:0] exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_data(input string name, input logic [rv_isa_pkg::data_w-1:0] got,
                          input logic [rv_isa_pkg::data_w-1:0] exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_kind(input string name, input rob_pkg::commit_kind_e got,
                          input rob_pkg::commit_kind_e exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

`endif

/* verification/rob_tb.sv */
`timescale 1ns/10ps

module rob_tb;

    localparam logic [3:0] kind_alu    = 4'd0;
    localparam logic [3:0] kind_store  = 4'd1;
    localparam logic [3:0] kind_branch = 4'd2;
    localparam logic [3:0] kind_end    = 4'd3;
    localparam int         step_limit  = 200;

    typedef struct packed {
        logic [3:0]                     kind;
        logic [rv_isa_pkg::regnm_w-1:0] regnm;
        logic [rv_isa_pkg::data_w-1:0]  data;
        logic                           pred;
        logic                           actual;
        logic [rv_isa_pkg::addr_w-1:0]  jump_pc;
        logic                           expect_commit;
        rob_pkg::tag_t                  tag;
    } rec_t;

    logic                           clk;
    logic                           rst;
    logic                           rdy;
    logic                           iss_en;
    logic [rv_isa_pkg::regnm_w-1:0] iss_regnm;
    logic                           full;
    logic                           tag_en;
    rob_pkg::tag_t                  tag;
    logic [rv_isa_pkg::regnm_w-1:0] tag_regnm;
    logic                           dp_en;
    rob_pkg::tag_t                  dp_tag;
    rv_isa_pkg::op_e                dp_op;
    logic                           dp_pred;
    logic [rv_isa_pkg::regnm_w-1:0] dp_regnm;
    logic                           ex_en;
    rob_pkg::tag_t                  ex_tag;
    logic [rv_isa_pkg::data_w-1:0]  ex_data;
    logic                           ex_actual;
    logic [rv_isa_pkg::addr_w-1:0]  ex_jump_pc;
    logic                           slb_en;
    rob_pkg::tag_t                  slb_tag;
    logic [rv_isa_pkg::data_w-1:0]  slb_data;
    logic                           store_commit_en;
    rob_pkg::tag_t                  store_commit_tag;
    logic                           rf_en;
    logic [rv_isa_pkg::regnm_w-1:0] rf_regnm;
    logic [rv_isa_pkg::data_w-1:0]  rf_data;
    rob_pkg::tag_t                  rf_tag;
    logic                           flush;
    logic [rv_isa_pkg::addr_w-1:0]  redirect_pc;

    // expected commits in program order, and pending store buffer answers
    rec_t                          commit_q[$];
    rec_t                          batch_q[$];
    int                            order_q[$];
    rob_pkg::tag_t                 slb_tag_q[$];
    logic [rv_isa_pkg::data_w-1:0] slb_data_q[$];

    rob_pkg::tag_t                 exp_tag;
    rec_t                          mon_rec;
    logic                          store_req_seen;
    logic                          flush_due;
    logic [rv_isa_pkg::addr_w-1:0] exp_redirect;
    int                            flush_count;
    logic [31:0]                   lfsr_state;

    rob_top i_dut (.*);

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    `include "rob_tb_checks.svh"

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // tags run 1..31 and skip 0
    function automatic rob_pkg::tag_t next_tag(input rob_pkg::tag_t t);
        return (t == 5'd31) ? 5'd1 : t + 5'd1;
    endfunction

    task automatic start_cycle();
        @(negedge clk);
        iss_en = 1'b0;
        dp_en  = 1'b0;
        ex_en  = 1'b0;
        slb_en = 1'b0;
        // answer a store request seen at the last edge
        if (slb_tag_q.size() != 0) begin
            slb_en   = 1'b1;
            slb_tag  = slb_tag_q.pop_front();
            slb_data = slb_data_q.pop_front();
        end
    endtask

    task automatic issue_record(input rec_t r, output rob_pkg::tag_t granted);
        start_cycle();
        r.tag = exp_tag;
        if (r.expect_commit) begin
            commit_q.push_back(r);
        end
        iss_en    = 1'b1;
        iss_regnm = r.regnm;
        dp_en     = 1'b1;
        dp_tag    = exp_tag;
        dp_pred   = r.pred;
        dp_regnm  = r.regnm;
        if (r.kind == kind_store) begin
            dp_op = rv_isa_pkg::op_sw;
        end else if (r.kind == kind_branch) begin
            dp_op = rv_isa_pkg::op_branch;
        end else begin
            dp_op = rv_isa_pkg::op_alu;
        end
        @(posedge clk);
        if (!tag_en) begin
            $display("issue request was not granted");
            abort_run();
        end
        check_tag("tag", tag, exp_tag);
        check_reg("tag_regnm", tag_regnm, r.regnm);
        granted = exp_tag;
        exp_tag = next_tag(exp_tag);
    endtask

    task automatic complete_entry(input rec_t r);
        start_cycle();
        ex_en      = 1'b1;
        ex_tag     = r.tag;
        ex_data    = r.data;
        ex_actual  = r.actual;
        ex_jump_pc = r.jump_pc;
    endtask

    task automatic shuffle_order();
        int j;
        int tmp;
        for (int k = order_q.size() - 1; k > 0; k--) begin
            j = rand_bits(5) % (k + 1);
            tmp = order_q[k];
            order_q[k] = order_q[j];
            order_q[j] = tmp;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        start_cycle();
        while (commit_q.size() != 0 || flush_due || slb_tag_q.size() != 0) begin
            if (waited == step_limit) begin
                $display("timeout while waiting for the buffer to drain");
                abort_run();
            end
            start_cycle();
            waited++;
        end
    endtask

    // issue in order, complete shuffled with a mispredict last, then drain
    task automatic process_batch();
        rec_t          r;
        rob_pkg::tag_t t;
        int            mis_idx;
        int            flushes_before;
        mis_idx = -1;
        flushes_before = flush_count;
        for (int i = 0; i < batch_q.size(); i++) begin
            r = batch_q[i];
            issue_record(r, t);
            r.tag = t;
            batch_q[i] = r;
            if (r.kind == kind_branch && r.pred != r.actual) begin
                mis_idx = i;
            end else if (r.kind != kind_store) begin
                order_q.push_back(i);
            end
        end
        shuffle_order();
        if (mis_idx >= 0) begin
            order_q.push_back(mis_idx);
        end
        for (int k = 0; k < order_q.size(); k++) begin
            complete_entry(batch_q[order_q[k]]);
        end
        drain();
        if (mis_idx >= 0) begin
            if (flush_count != flushes_before + 1) begin
                $display("mispredicted branch did not produce exactly one flush");
                abort_run();
            end
            exp_tag = 5'd1;
        end
        batch_q.delete();
        order_q.delete();
    endtask

    task automatic replay_golden_file();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_kind;
        logic [31:0] f_regnm;
        logic [31:0] f_data;
        logic [31:0] f_pred;
        logic [31:0] f_actual;
        logic [31:0] f_pc;
        logic [31:0] f_commit;
        rec_t        r;
        fd = $fopen("verification/rob_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", f_kind, f_regnm, f_data,
                            f_pred, f_actual, f_pc, f_commit);
                if (n != 7) begin
                    $display("malformed line in the golden file");
                    abort_run();
                end
                if (f_kind[3:0] == kind_end) begin
                    process_batch();
                end else begin
                    r.kind          = f_kind[3:0];
                    r.regnm         = f_regnm[rv_isa_pkg::regnm_w-1:0];
                    r.data          = f_data;
                    r.pred          = f_pred[0];
                    r.actual        = f_actual[0];
                    r.jump_pc       = f_pc;
                    r.expect_commit = f_commit[0];
                    r.tag           = 5'd0;
                    batch_q.push_back(r);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic fill_stall_and_wrap();
        rec_t          r;
        rob_pkg::tag_t t;
        for (int i = 0; i < 31; i++) begin
            r.kind          = kind_alu;
            r.regnm         = 5'(i + 1);
            r.data          = rand_bits(32);
            r.pred          = 1'b0;
            r.actual        = 1'b0;
            r.jump_pc       = '0;
            r.expect_commit = 1'b1;
            issue_record(r, t);
            r.tag = t;
            batch_q.push_back(r);
        end
        start_cycle();
        if (!full) begin
            $display("full not raised after 31 grants");
            abort_run();
        end
        iss_en    = 1'b1;
        iss_regnm = 5'd1;
        @(posedge clk);
        if (tag_en) begin
            $display("grant given while the buffer is full");
            abort_run();
        end
        // head done, then freeze it
        complete_entry(batch_q[0]);
        for (int i = 0; i < 6; i++) begin
            start_cycle();
            rdy    = 1'b0;
            iss_en = 1'b1;
        end
        if (commit_q.size() != 31) begin
            $display("an entry committed while rdy was low");
            abort_run();
        end
        rdy = 1'b1;
        for (int i = 1; i < 31; i++) begin
            order_q.push_back(i);
        end
        shuffle_order();
        for (int k = 0; k < order_q.size(); k++) begin
            complete_entry(batch_q[order_q[k]]);
        end
        drain();
        batch_q.delete();
        order_q.delete();
        // a few more past the wrap point
        for (int i = 0; i < 3; i++) begin
            r.regnm = 5'(20 + i);
            r.data  = rand_bits(32);
            batch_q.push_back(r);
        end
        process_batch();
    endtask

    always @(posedge clk) begin : commit_monitor
        if (!rst) begin
            if (!rdy) begin
                if (rf_en || store_commit_en || tag_en || flush) begin
                    $display("strobe high while rdy is low");
                    abort_run();
                end
            end else begin
                if (flush_due) begin
                    if (!flush || rf_en || store_commit_en || tag_en) begin
                        $display("flush cycle after a mispredict is wrong");
                        abort_run();
                    end
                    check_data("redirect_pc", redirect_pc, exp_redirect);
                    flush_due = 1'b0;
                    flush_count++;
                end else if (flush) begin
                    $display("flush without a mispredicted commit");
                    abort_run();
                end
                if (rf_en) begin
                    if (commit_q.size() == 0 || commit_q[0].kind == kind_store) begin
                        $display("register write where none was expected");
                        abort_run();
                    end
                    mon_rec = commit_q.pop_front();
                    check_tag("rf_tag", rf_tag, mon_rec.tag);
                    check_reg("rf_regnm", rf_regnm, mon_rec.regnm);
                    check_data("rf_data", rf_data, mon_rec.data);
                    if (mon_rec.kind == kind_branch && mon_rec.pred != mon_rec.actual) begin
                        check_kind("kind", i_dut.i_commit.kind, rob_pkg::commit_mispredict);
                        flush_due    = 1'b1;
                        exp_redirect = mon_rec.jump_pc;
                    end else begin
                        check_kind("kind", i_dut.i_commit.kind, rob_pkg::commit_reg);
                    end
                end
                if (store_commit_en) begin
                    if (commit_q.size() == 0 || commit_q[0].kind != kind_store ||
                        store_req_seen) begin
                        $display("unexpected store commit request");
                        abort_run();
                    end
                    check_tag("store_commit_tag", store_commit_tag, commit_q[0].tag);
                    store_req_seen = 1'b1;
                    slb_tag_q.push_back(commit_q[0].tag);
                    slb_data_q.push_back(commit_q[0].data);
                end
                if (i_dut.i_commit.kind == rob_pkg::commit_store_retire) begin
                    if (commit_q.size() == 0 || !store_req_seen) begin
                        $display("store retired without a request");
                        abort_run();
                    end
                    mon_rec = commit_q.pop_front();
                    check_tag("store retire tag", rf_tag, mon_rec.tag);
                    store_req_seen = 1'b0;
                end
            end
        end
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        rdy            = 1'b1;
        iss_en         = 1'b0;
        iss_regnm      = '0;
        dp_en          = 1'b0;
        dp_tag         = '0;
        dp_op          = rv_isa_pkg::op_alu;
        dp_pred        = 1'b0;
        dp_regnm       = '0;
        ex_en          = 1'b0;
        ex_tag         = '0;
        ex_data        = '0;
        ex_actual      = 1'b0;
        ex_jump_pc     = '0;
        slb_en         = 1'b0;
        slb_tag        = '0;
        slb_data       = '0;
        exp_tag        = 5'd1;
        store_req_seen = 1'b0;
        flush_due      = 1'b0;
        exp_redirect   = '0;
        flush_count    = 0;
        lfsr_state     = 32'd50;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        if (rf_en || store_commit_en || tag_en || flush || full) begin
            $display("strobe or full high right after reset");
            abort_run();
        end
        replay_golden_file();
        fill_stall_and_wrap();
        start_cycle();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
